// ==== hdl/mcu_pkg.sv ====
// Shared types for the auxiliary MCU core and its host bus interface
// Instruction words are 16 bits, data is 8 bits, main RAM is byte addressed
// Opcode and ALU function values are fixed by the program ROM image format
package mcu_pkg;

    // Main opcode in the top nibble of every instruction
    typedef enum logic [3:0] {
        NOP  = 4'h0,
        MOVI = 4'h1,
        ALU  = 4'h2,
        ADDI = 4'h3,
        LD   = 4'h4,
        ST   = 4'h5,
        JMP  = 4'h6,
        CLRI = 4'h7,
        HALT = 4'h8
    } mcu_op_e;

    // ALU function, low 3 bits of imm8 in ALU instructions
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        MOV = 3'd5
    } alu_fn_e;

    // Jump conditions, IRQ tests the host request latch
    typedef enum logic [1:0] {
        ALWAYS   = 2'd0,
        ZERO     = 2'd1,
        NOT_ZERO = 2'd2,
        IRQ      = 2'd3
    } jmp_cond_e;

    // Core sequencer, one step per clock enable
    typedef enum logic [1:0] {
        FETCH   = 2'd0,
        DECODE  = 2'd1,
        EXECUTE = 2'd2,
        RESULT  = 2'd3
    } stage_e;

    // Register and immediate format
    typedef struct packed {
        mcu_op_e     opcode;
        logic [1:0]  rd;
        logic [1:0]  rs;
        logic [7:0]  imm8;
    } alu_fmt_t;

    // Jump format, target is a ROM word address
    typedef struct packed {
        mcu_op_e     opcode;
        jmp_cond_e   cond;
        logic [1:0]  spare;
        logic [7:0]  target;
    } jmp_fmt_t;

    // Same word, two views
    typedef union packed {
        alu_fmt_t alu_fmt;
        jmp_fmt_t jmp_fmt;
    } mcu_instr_u;

    // Decoded operation, held from DECODE until the next DECODE
    typedef struct packed {
        mcu_op_e     opcode;
        logic [1:0]  rd;
        logic [1:0]  rs;
        logic [7:0]  imm8;
        alu_fn_e     alu_fn;
        logic        src_imm;
        jmp_cond_e   cond;
        logic [7:0]  target;
    } dec_op_t;

    // Execute outputs consumed in RESULT
    typedef struct packed {
        logic [7:0]  alu_val;
        logic        zero;
        logic        reg_we;
        logic [1:0]  rd;
        logic        jmp_taken;
        logic [7:0]  jmp_target;
        logic        clr_req;
        logic        halt;
    } exe_res_t;

    // Byte access towards main RAM
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        wr;
        logic        acc;
    } bus_req_t;

endpackage

// ==== hdl/mcu_prog_rom.sv ====
// Program memory of 2**ROM_AW 16-bit words, no reset contents
// Host writes are only meant to happen while the core is held in reset
// Read data changes only on rd_en_i and holds between enables
`timescale 1ns/1ps

module mcu_prog_rom
    import mcu_pkg::*;
#(
    parameter int ROM_AW = 8
) (
    input  logic              clk,
    // Host programming port
    input  logic [ROM_AW-1:0] prog_addr_i,
    input  logic [15:0]       prog_data_i,
    input  logic              prog_we_i,
    // Core fetch port
    input  logic [ROM_AW-1:0] rd_addr_i,
    input  logic              rd_en_i,
    output mcu_instr_u        rd_data_o
);

    logic [15:0] mem [2**ROM_AW];
    mcu_instr_u  rd_q;

    always_ff @(posedge clk) begin
        // One word per clk from the host
        if (prog_we_i) begin
            mem[prog_addr_i] <= prog_data_i;
        end
        // Registered read at the PC
        if (rd_en_i) begin
            rd_q <= mem[rd_addr_i];
        end
    end

    assign rd_data_o = rd_q;

endmodule

// ==== hdl/mcu_decode.sv ====
// Instruction decoder, registers one decoded operation per DECODE enable
// Unknown opcodes become NOP with all fields cleared
// ALU function codes 6 and 7 are passed on unchanged
`timescale 1ns/1ps

module mcu_decode
    import mcu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_cpu,
    input  logic       cen_i,
    input  stage_e     stage_i,
    input  mcu_instr_u instr_i,
    output dec_op_t    op_o
);

    dec_op_t dec;
    dec_op_t op_q;

    always_comb begin
        dec = '0;
        // Register fields come from the ALU view
        dec.opcode = instr_i.alu_fmt.opcode;
        dec.rd     = instr_i.alu_fmt.rd;
        dec.rs     = instr_i.alu_fmt.rs;
        dec.imm8   = instr_i.alu_fmt.imm8;
        case (instr_i.alu_fmt.opcode)
            NOP, LD, ST, CLRI, HALT: begin
                // Fields as read, no ALU use
                dec.alu_fn = ADD;
            end
            MOVI: begin
                // Copy of the immediate
                dec.alu_fn  = MOV;
                dec.src_imm = 1'b1;
            end
            ALU: begin
                dec.alu_fn = alu_fn_e'(instr_i.alu_fmt.imm8[2:0]);
            end
            ADDI: begin
                dec.alu_fn  = ADD;
                dec.src_imm = 1'b1;
            end
            JMP: begin
                // Condition and target from the jump view
                dec.cond   = instr_i.jmp_fmt.cond;
                dec.target = instr_i.jmp_fmt.target;
            end
            default: begin
                // Anything else is a NOP
                dec = '0;
            end
        endcase
    end

    always_ff @(posedge clk, posedge rst_cpu) begin
        if (rst_cpu) begin
            op_q <= '0;
        end else if (cen_i && stage_i == DECODE) begin
            op_q <= dec;
        end
    end

    // Held stable through EXECUTE and RESULT
    assign op_o = op_q;

endmodule

// ==== hdl/mcu_execute.sv ====
// Register file, ALU and bus access for one instruction at a time
// Address of LD and ST is {rs, imm8}, store data is rd
// Load data must be valid at the RESULT clock enable
`timescale 1ns/1ps

module mcu_execute
    import mcu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_cpu,
    input  logic     cen_i,
    input  stage_e   stage_i,
    input  dec_op_t  op_i,
    input  logic     irq_i,
    input  logic [7:0] ld_byte_i,
    output exe_res_t res_o,
    output bus_req_t req_o
);

    logic [7:0]  regs [4];
    logic        zero_q;
    logic [7:0]  opa;
    logic [7:0]  opb;
    logic [7:0]  alu;
    logic        cond_ok;
    logic        is_mem;
    logic        is_ld;
    logic [7:0]  wb_val;
    logic        wb_zero;
    exe_res_t    res_q;
    logic [15:0] addr_q;
    logic [7:0]  wdata_q;
    logic        wr_q;
    logic        acc_q;

    // Operands, second one can be the immediate
    assign opa = regs[op_i.rd];
    assign opb = op_i.src_imm ? op_i.imm8 : regs[op_i.rs];

    always_comb begin
        case (op_i.alu_fn)
            ADD:     alu = opa + opb;
            SUB:     alu = opa - opb;
            AND:     alu = opa & opb;
            OR:      alu = opa | opb;
            XOR:     alu = opa ^ opb;
            default: alu = opb;
        endcase
    end

    // Condition uses the flag left by the previous instruction
    always_comb begin
        case (op_i.cond)
            ALWAYS:   cond_ok = 1'b1;
            ZERO:     cond_ok = zero_q;
            NOT_ZERO: cond_ok = !zero_q;
            default:  cond_ok = irq_i;
        endcase
    end

    assign is_ld  = op_i.opcode == LD;
    assign is_mem = is_ld || op_i.opcode == ST;

    // Loads take the steered bus byte instead of the ALU value
    assign wb_val  = is_ld ? ld_byte_i : res_q.alu_val;
    assign wb_zero = is_ld ? (ld_byte_i == 8'h00) : res_q.zero;

    always_ff @(posedge clk, posedge rst_cpu) begin
        if (rst_cpu) begin
            res_q  <= '0;
            zero_q <= 1'b0;
            acc_q  <= 1'b0;
            wr_q   <= 1'b0;
            for (int i = 0; i < 4; i++) begin
                regs[i] <= 8'h00;
            end
        end else begin
            // Strobe lasts one clk
            acc_q <= 1'b0;
            wr_q  <= 1'b0;
            if (cen_i && stage_i == EXECUTE) begin
                res_q.alu_val    <= alu;
                res_q.zero       <= alu == 8'h00;
                res_q.reg_we     <= op_i.opcode inside {MOVI, ALU, ADDI, LD};
                res_q.rd         <= op_i.rd;
                res_q.jmp_taken  <= op_i.opcode == JMP && cond_ok;
                res_q.jmp_target <= op_i.target;
                res_q.clr_req    <= op_i.opcode == CLRI;
                res_q.halt       <= op_i.opcode == HALT;
                acc_q            <= is_mem;
                wr_q             <= op_i.opcode == ST;
            end
            // Flag follows only instructions that write a register
            if (cen_i && stage_i == RESULT && res_q.reg_we) begin
                regs[res_q.rd] <= wb_val;
                zero_q         <= wb_zero;
            end
        end
    end

    // Address and data stay put after the strobe
    always_ff @(posedge clk) begin
        if (cen_i && stage_i == EXECUTE && is_mem) begin
            addr_q  <= {regs[op_i.rs], op_i.imm8};
            wdata_q <= regs[op_i.rd];
        end
    end

    assign res_o     = res_q;
    assign req_o.addr  = addr_q;
    assign req_o.wdata = wdata_q;
    assign req_o.wr    = wr_q;
    assign req_o.acc   = acc_q;

endmodule

// ==== hdl/mcu_result.sv ====
// Program counter and end-of-instruction actions
// Jump targets are 8 bits and are resized to ROM_AW
// Halt is sticky until reset
`timescale 1ns/1ps

module mcu_result
    import mcu_pkg::*;
#(
    parameter int ROM_AW = 8
) (
    input  logic              clk,
    input  logic              rst_cpu,
    input  logic              cen_i,
    input  stage_e            stage_i,
    input  exe_res_t          res_i,
    output logic [ROM_AW-1:0] pc_o,
    output logic              clr_req_o,
    output logic              halt_o
);

    logic [ROM_AW-1:0] pc_q;
    logic [ROM_AW-1:0] pc_next;
    logic              clr_q;
    logic              halt_q;
    logic              res_cen;

    // End of the instruction
    assign res_cen = cen_i && stage_i == RESULT;

    // Taken jump or next word, wraps at the ROM end
    always_comb begin
        if (res_i.jmp_taken) begin
            pc_next = ROM_AW'(res_i.jmp_target);
        end else begin
            pc_next = pc_q + 1'b1;
        end
    end

    always_ff @(posedge clk, posedge rst_cpu) begin
        if (rst_cpu) begin
            pc_q   <= '0;
            clr_q  <= 1'b0;
            halt_q <= 1'b0;
        end else begin
            clr_q <= 1'b0;
            if (res_cen) begin
                pc_q  <= pc_next;
                // One clk pulse to the request latch
                clr_q <= res_i.clr_req;
                if (res_i.halt) begin
                    halt_q <= 1'b1;
                end
            end
        end
    end

    // PC is read by the ROM on every enable
    assign pc_o      = pc_q;
    assign clr_req_o = clr_q;
    assign halt_o    = halt_q;

endmodule

// ==== hdl/mcu_host_if.sv ====
// Host side of the core, clock enable, sequencer, request latch, lanes
// Single clock, dma_on_n_i must already be synchronous to clk
// No wait states, read data must hold until the next clock enable
`timescale 1ns/1ps

module mcu_host_if
    import mcu_pkg::*;
#(
    parameter int CEN_DIV = 36
) (
    input  logic        clk,
    input  logic        rst_cpu,
    input  logic        dma_on_n_i,
    input  logic        halt_i,
    input  logic        clr_req_i,
    input  bus_req_t    req_i,
    input  logic [15:0] bus_din_i,
    output logic        cen_o,
    output stage_e      stage_o,
    output logic        irq_o,
    output logic [7:0]  rd_byte_o,
    output logic [14:0] bus_addr_o,
    output logic [7:0]  bus_dout_o,
    output logic        bus_wr_o,
    output logic        bus_acc_o,
    output logic        bus_ds_o,
    output logic        bus_req_n_o
);

    localparam int CW = $clog2(CEN_DIV);

    logic [CW-1:0] cnt_q;
    stage_e        stage_q;
    logic          dma_last_q;
    logic          req_n_q;

    // Enable divider, runs out of reset
    always_ff @(posedge clk, posedge rst_cpu) begin
        if (rst_cpu) begin
            cnt_q <= '0;
        end else if (cnt_q == CW'(CEN_DIV - 1)) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Core stops completely once halted
    assign cen_o = cnt_q == CW'(CEN_DIV - 1) && !halt_i;

    // Four steps per instruction, wraps back to FETCH
    always_ff @(posedge clk, posedge rst_cpu) begin
        if (rst_cpu) begin
            stage_q <= FETCH;
        end else if (cen_o) begin
            stage_q <= stage_e'(stage_q + 2'd1);
        end
    end

    // Request latch, set by a DMA-off rise, clear has priority
    always_ff @(posedge clk, posedge rst_cpu) begin
        if (rst_cpu) begin
            dma_last_q <= 1'b1;
            req_n_q    <= 1'b1;
        end else begin
            dma_last_q <= dma_on_n_i;
            if (clr_req_i) begin
                req_n_q <= 1'b1;
            end else if (dma_on_n_i && !dma_last_q) begin
                req_n_q <= 1'b0;
            end
        end
    end

    assign stage_o     = stage_q;
    assign irq_o       = !req_n_q;
    assign bus_req_n_o = req_n_q;

    // Word address and lane, odd byte is the low lane
    assign bus_addr_o = req_i.addr[15:1];
    assign bus_ds_o   = req_i.addr[0];
    assign bus_dout_o = req_i.wdata;
    assign bus_wr_o   = req_i.wr;
    assign bus_acc_o  = req_i.acc;

    // High byte sits at the even address
    assign rd_byte_o = bus_ds_o ? bus_din_i[7:0] : bus_din_i[15:8];

endmodule

// ==== hdl/mcu_top.sv ====
// Auxiliary MCU subsystem beside the main CPU, sharing its 16-bit work RAM
// CEN_DIV is the clk count per core step, at least 2
// ROM programming is only valid while rst_cpu is high
`timescale 1ns/1ps

module mcu_top
    import mcu_pkg::*;
#(
    parameter int CEN_DIV = 36,
    parameter int ROM_AW  = 8
) (
    input  logic              clk,
    input  logic              rst_cpu,
    // Main CPU bus
    input  logic [15:0]       bus_din_i,
    output logic [14:0]       bus_addr_o,
    output logic [7:0]        bus_dout_o,
    output logic              bus_wr_o,
    output logic              bus_acc_o,
    output logic              bus_ds_o,
    output logic              bus_req_n_o,
    input  logic              dma_on_n_i,
    // ROM programming
    input  logic [ROM_AW-1:0] prog_addr_i,
    input  logic [15:0]       prog_data_i,
    input  logic              prog_we_i,
    output logic              halted_o
);

    logic              cen;
    stage_e            stage;
    mcu_instr_u        instr;
    dec_op_t           dec_op;
    exe_res_t          exe_res;
    bus_req_t          bus_req;
    logic              irq;
    logic [7:0]        rd_byte;
    logic [ROM_AW-1:0] pc;
    logic              clr_req;

    // Read on every enable, PC only moves at RESULT
    mcu_prog_rom #(.ROM_AW(ROM_AW)) u_rom (
        .clk         (clk),
        .prog_addr_i (prog_addr_i),
        .prog_data_i (prog_data_i),
        .prog_we_i   (prog_we_i),
        .rd_addr_i   (pc),
        .rd_en_i     (cen),
        .rd_data_o   (instr)
    );

    mcu_decode u_decode (
        .clk     (clk),
        .rst_cpu (rst_cpu),
        .cen_i   (cen),
        .stage_i (stage),
        .instr_i (instr),
        .op_o    (dec_op)
    );

    mcu_execute u_execute (
        .clk       (clk),
        .rst_cpu   (rst_cpu),
        .cen_i     (cen),
        .stage_i   (stage),
        .op_i      (dec_op),
        .irq_i     (irq),
        .ld_byte_i (rd_byte),
        .res_o     (exe_res),
        .req_o     (bus_req)
    );

    mcu_result #(.ROM_AW(ROM_AW)) u_result (
        .clk       (clk),
        .rst_cpu   (rst_cpu),
        .cen_i     (cen),
        .stage_i   (stage),
        .res_i     (exe_res),
        .pc_o      (pc),
        .clr_req_o (clr_req),
        .halt_o    (halted_o)
    );

    mcu_host_if #(.CEN_DIV(CEN_DIV)) u_host_if (
        .clk         (clk),
        .rst_cpu     (rst_cpu),
        .dma_on_n_i  (dma_on_n_i),
        .halt_i      (halted_o),
        .clr_req_i   (clr_req),
        .req_i       (bus_req),
        .bus_din_i   (bus_din_i),
        .cen_o       (cen),
        .stage_o     (stage),
        .irq_o       (irq),
        .rd_byte_o   (rd_byte),
        .bus_addr_o  (bus_addr_o),
        .bus_dout_o  (bus_dout_o),
        .bus_wr_o    (bus_wr_o),
        .bus_acc_o   (bus_acc_o),
        .bus_ds_o    (bus_ds_o),
        .bus_req_n_o (bus_req_n_o)
    );

endmodule

// ==== verification/mcu_assertions.sv ====
// Bus strobe and request latch properties, bound into mcu_host_if
// Sampled on clk, all checks are off while rst_cpu is high
`timescale 1ns/1ps

module mcu_assertions (
    input logic clk,
    input logic rst_cpu,
    input logic bus_acc_i,
    input logic bus_wr_i,
    input logic bus_req_n_i,
    input logic dma_on_n_i
);

    // Strobe never longer than one clk
    acc_one_clk: assert property (
        @(posedge clk) disable iff (rst_cpu) bus_acc_i |=> !bus_acc_i
    ) else $error("bus_acc_o held for more than one clk");

    // Write flag only together with the strobe
    wr_with_acc: assert property (
        @(posedge clk) disable iff (rst_cpu) bus_wr_i |-> bus_acc_i
    ) else $error("bus_wr_o high without bus_acc_o");

    // Latch sets one clk after the DMA line rose
    req_after_rise: assert property (
        @(posedge clk) disable iff (rst_cpu)
        $fell(bus_req_n_i) |-> $past(dma_on_n_i) && !$past(dma_on_n_i, 2)
    ) else $error("bus_req_n_o fell without a dma_on_n_i rise");

endmodule

bind mcu_host_if mcu_assertions u_assertions (
    .clk         (clk),
    .rst_cpu     (rst_cpu),
    .bus_acc_i   (bus_acc_o),
    .bus_wr_i    (bus_wr_o),
    .bus_req_n_i (bus_req_n_o),
    .dma_on_n_i  (dma_on_n_i)
);

// ==== verification/mcu_tb.sv ====
// Testbench for mcu_top with CEN_DIV of 4, programs loaded while in reset
// RAM model covers the full 15-bit word space, no wait states
// Expected stores come from a software model of the instruction set
`timescale 1ns/1ps

module mcu_tb
    import mcu_pkg::*;
;

    localparam int CEN_DIV   = 4;
    localparam int NUM_TESTS = 4;
    localparam int MAX_INSTR = 200;
    localparam int WATCH_NS  = NUM_TESTS * MAX_INSTR * 4 * CEN_DIV * 40 + 20000;

    logic        clk;
    logic        rst_cpu;
    logic [15:0] bus_din_i;
    logic [14:0] bus_addr_o;
    logic [7:0]  bus_dout_o;
    logic        bus_wr_o;
    logic        bus_acc_o;
    logic        bus_ds_o;
    logic        bus_req_n_o;
    logic        dma_on_n_i;
    logic [7:0]  prog_addr_i;
    logic [15:0] prog_data_i;
    logic        prog_we_i;
    logic        halted_o;

    logic [15:0] ram_mem [32768];
    logic [15:0] ref_ram [32768];
    logic [15:0] prog [256];
    int          prog_len;
    logic [15:0] exp_addr [$];
    logic [7:0]  exp_data [$];
    int          errors;
    int          writes_seen;
    int          seed;

    mcu_top #(.CEN_DIV(CEN_DIV), .ROM_AW(8)) dut (
        .clk         (clk),
        .rst_cpu     (rst_cpu),
        .bus_din_i   (bus_din_i),
        .bus_addr_o  (bus_addr_o),
        .bus_dout_o  (bus_dout_o),
        .bus_wr_o    (bus_wr_o),
        .bus_acc_o   (bus_acc_o),
        .bus_ds_o    (bus_ds_o),
        .bus_req_n_o (bus_req_n_o),
        .dma_on_n_i  (dma_on_n_i),
        .prog_addr_i (prog_addr_i),
        .prog_data_i (prog_data_i),
        .prog_we_i   (prog_we_i),
        .halted_o    (halted_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Watchdog sized from the test count and the longest program
    initial begin
        #(WATCH_NS);
        $display("ERROR: timeout, the core never reached HALT");
        $display("TESTS FAILED");
        $finish;
    end

    // RAM model, read word valid one clk after the strobe
    always @(posedge clk) begin
        if (bus_acc_o) begin
            if (bus_wr_o && bus_ds_o) begin
                ram_mem[bus_addr_o][7:0] = bus_dout_o;
            end else if (bus_wr_o) begin
                ram_mem[bus_addr_o][15:8] = bus_dout_o;
            end else begin
                bus_din_i <= ram_mem[bus_addr_o];
            end
        end
    end

    // Compare each store against the expected sequence
    always @(posedge clk) begin
        if (bus_acc_o && bus_wr_o) begin
            writes_seen++;
            if (exp_addr.size() == 0) begin
                $display("ERROR: unexpected store to byte address %h", {bus_addr_o, bus_ds_o});
                errors++;
            end else begin
                if ({bus_addr_o, bus_ds_o} !== exp_addr[0]) begin
                    $display("CHECK FAILED bus_addr_o/bus_ds_o got %h expected %h",
                             {bus_addr_o, bus_ds_o}, exp_addr[0]);
                    errors++;
                end
                if (bus_dout_o !== exp_data[0]) begin
                    $display("CHECK FAILED bus_dout_o got %h expected %h",
                             bus_dout_o, exp_data[0]);
                    errors++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    function automatic logic [15:0] enc(mcu_op_e op, logic [1:0] rd, logic [1:0] rs,
                                        logic [7:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic logic [15:0] jmp(jmp_cond_e cond, logic [7:0] target);
        return {JMP, cond, 2'b00, target};
    endfunction

    task automatic emit(logic [15:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    // Instruction set model, fills the expected store queues
    function automatic void predict_stores(bit irq_in);
        logic [7:0]  r [4];
        logic        z;
        logic        irq;
        logic [15:0] w;
        logic [15:0] ad;
        logic [7:0]  imm;
        logic [7:0]  a;
        logic [7:0]  b;
        logic [7:0]  v;
        logic        take;
        int          pc;
        int          steps;
        bit          done;
        for (int i = 0; i < 4; i++) begin
            r[i] = 8'h00;
        end
        z = 1'b0;
        irq = irq_in;
        pc = 0;
        steps = 0;
        done = 0;
        while (!done && steps < MAX_INSTR) begin
            w = prog[pc];
            imm = w[7:0];
            a = r[w[11:10]];
            b = r[w[9:8]];
            ad = {b, imm};
            pc = (pc + 1) % 256;
            steps++;
            case (w[15:12])
                4'h1: begin
                    r[w[11:10]] = imm;
                    z = imm == 8'h00;
                end
                4'h2: begin
                    case (imm[2:0])
                        3'd0: v = a + b;
                        3'd1: v = a - b;
                        3'd2: v = a & b;
                        3'd3: v = a | b;
                        3'd4: v = a ^ b;
                        default: v = b;
                    endcase
                    r[w[11:10]] = v;
                    z = v == 8'h00;
                end
                4'h3: begin
                    v = a + imm;
                    r[w[11:10]] = v;
                    z = v == 8'h00;
                end
                4'h4: begin
                    // Even byte address is the high half of the word
                    v = ad[0] ? ref_ram[ad[15:1]][7:0] : ref_ram[ad[15:1]][15:8];
                    r[w[11:10]] = v;
                    z = v == 8'h00;
                end
                4'h5: begin
                    exp_addr.push_back(ad);
                    exp_data.push_back(a);
                    if (ad[0]) begin
                        ref_ram[ad[15:1]][7:0] = a;
                    end else begin
                        ref_ram[ad[15:1]][15:8] = a;
                    end
                end
                4'h6: begin
                    case (w[11:10])
                        2'd0: take = 1'b1;
                        2'd1: take = z;
                        2'd2: take = !z;
                        default: take = irq;
                    endcase
                    if (take) begin
                        pc = int'(w[7:0]);
                    end
                end
                4'h7: irq = 1'b0;
                4'h8: done = 1;
                default: ;
            endcase
        end
    endfunction

    task automatic fill_ram();
        int tmp;
        for (int i = 0; i < 32768; i++) begin
            tmp = $random(seed);
            ram_mem[i] = tmp[15:0];
        end
    endtask

    // Reset, ROM load and the idle state of the outputs
    task automatic reset_and_load(logic dma_level);
        @(posedge clk);
        rst_cpu <= 1'b1;
        dma_on_n_i <= dma_level;
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            prog_we_i   <= 1'b1;
            prog_addr_i <= 8'(i);
            prog_data_i <= prog[i];
        end
        @(posedge clk);
        prog_we_i <= 1'b0;
        repeat (8) @(posedge clk);
        if (bus_acc_o !== 1'b0 || bus_wr_o !== 1'b0 || halted_o !== 1'b0) begin
            $display("CHECK FAILED acc/wr/halted in reset got %h expected 0",
                     {bus_acc_o, bus_wr_o, halted_o});
            errors++;
        end
        if (bus_req_n_o !== 1'b1) begin
            $display("CHECK FAILED bus_req_n_o in reset got %h expected 1", bus_req_n_o);
            errors++;
        end
        rst_cpu <= 1'b0;
        // First strobe comes after the third enable at the earliest
        repeat (2 * CEN_DIV) begin
            @(posedge clk);
            if (bus_acc_o !== 1'b0 || bus_wr_o !== 1'b0 || halted_o !== 1'b0
                || bus_req_n_o !== 1'b1) begin
                $display("CHECK FAILED acc/wr/halted/req_n after reset got %h expected 1",
                         {bus_acc_o, bus_wr_o, halted_o, bus_req_n_o});
                errors++;
            end
        end
    endtask

    task automatic run_test(string name, bit with_dma);
        int err_start;
        int exp_count;
        err_start = errors;
        for (int i = 0; i < 32768; i++) begin
            ref_ram[i] = ram_mem[i];
        end
        exp_addr.delete();
        exp_data.delete();
        predict_stores(with_dma);
        exp_count = exp_addr.size();
        writes_seen = 0;
        reset_and_load(with_dma ? 1'b0 : 1'b1);
        if (with_dma) begin
            // Let the core spin on JMP IRQ for a while
            repeat (10 * 4 * CEN_DIV) @(posedge clk);
            dma_on_n_i <= 1'b1;
            @(posedge clk);
            @(posedge clk);
            if (bus_req_n_o !== 1'b0) begin
                $display("CHECK FAILED bus_req_n_o after edge got %h expected 0", bus_req_n_o);
                errors++;
            end
        end
        while (!halted_o) @(posedge clk);
        if (writes_seen != exp_count) begin
            $display("ERROR: %0d stores seen, %0d expected", writes_seen, exp_count);
            errors++;
        end
        if (with_dma && bus_req_n_o !== 1'b1) begin
            $display("CHECK FAILED bus_req_n_o at halt got %h expected 1", bus_req_n_o);
            errors++;
        end
        $display("test %s finished, %0d stores, %0d errors", name, writes_seen,
                 errors - err_start);
    endtask

    initial begin
        logic [7:0] opa;
        logic [7:0] opb;
        logic [7:0] addc;
        int         tmp;
        rst_cpu     = 1'b1;
        bus_din_i   = 16'h0000;
        dma_on_n_i  = 1'b1;
        prog_addr_i = 8'h00;
        prog_data_i = 16'h0000;
        prog_we_i   = 1'b0;
        errors      = 0;
        writes_seen = 0;
        seed        = 32'hd827;
        fill_ram();

        // Every ALU function and ADDI on random operands
        tmp = $random(seed);
        opa = tmp[7:0];
        tmp = $random(seed);
        opb = tmp[7:0];
        tmp = $random(seed);
        addc = tmp[7:0];
        prog_len = 0;
        emit(enc(MOVI, 2'd0, 2'd0, opa));
        emit(enc(MOVI, 2'd1, 2'd0, opb));
        emit(enc(MOVI, 2'd3, 2'd0, 8'h10));
        for (int f = 0; f < 6; f++) begin
            emit(enc(ALU, 2'd2, 2'd0, 8'h05));
            emit(enc(ALU, 2'd2, 2'd1, 8'(f)));
            emit(enc(ST, 2'd2, 2'd3, 8'(f)));
        end
        emit(enc(ADDI, 2'd0, 2'd0, addc));
        emit(enc(ST, 2'd0, 2'd3, 8'h06));
        emit(enc(HALT, 2'd0, 2'd0, 8'h00));
        run_test("alu_immediates", 1'b0);

        // Loads from both lanes, then stores elsewhere
        fill_ram();
        prog_len = 0;
        emit(enc(MOVI, 2'd3, 2'd0, 8'h20));
        emit(enc(LD, 2'd0, 2'd3, 8'h04));
        emit(enc(LD, 2'd1, 2'd3, 8'h05));
        emit(enc(LD, 2'd2, 2'd3, 8'h0b));
        emit(enc(MOVI, 2'd3, 2'd0, 8'h30));
        emit(enc(ST, 2'd0, 2'd3, 8'h01));
        emit(enc(ST, 2'd1, 2'd3, 8'h02));
        emit(enc(ST, 2'd2, 2'd3, 8'h07));
        emit(enc(HALT, 2'd0, 2'd0, 8'h00));
        run_test("byte_lanes", 1'b0);

        // Countdown loop, then a ZERO skip and an ALWAYS jump
        prog_len = 0;
        emit(enc(MOVI, 2'd0, 2'd0, 8'h05));
        emit(enc(MOVI, 2'd3, 2'd0, 8'h40));
        emit(enc(MOVI, 2'd1, 2'd0, 8'h01));
        emit(enc(ST, 2'd0, 2'd0, 8'h80));
        emit(enc(ALU, 2'd0, 2'd1, 8'h01));
        emit(jmp(NOT_ZERO, 8'd3));
        emit(jmp(ZERO, 8'd8));
        emit(enc(ST, 2'd1, 2'd3, 8'hff));
        emit(jmp(ALWAYS, 8'd10));
        emit(enc(ST, 2'd1, 2'd3, 8'hfe));
        emit(enc(ST, 2'd0, 2'd3, 8'h00));
        emit(enc(HALT, 2'd0, 2'd0, 8'h00));
        run_test("jumps_zero_flag", 1'b0);

        // Spin on the request latch, clear it and store a marker
        prog_len = 0;
        emit(jmp(IRQ, 8'd2));
        emit(jmp(ALWAYS, 8'd0));
        emit(enc(CLRI, 2'd0, 2'd0, 8'h00));
        emit(enc(MOVI, 2'd0, 2'd0, 8'ha5));
        emit(enc(MOVI, 2'd3, 2'd0, 8'h50));
        emit(enc(ST, 2'd0, 2'd3, 8'h00));
        emit(enc(HALT, 2'd0, 2'd0, 8'h00));
        run_test("host_request", 1'b1);

        $display("%0d tests run, %0d errors", NUM_TESTS, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
hdl/mcu_pkg.sv
hdl/mcu_prog_rom.sv
hdl/mcu_decode.sv
hdl/mcu_execute.sv
hdl/mcu_result.sv
hdl/mcu_host_if.sv
hdl/mcu_top.sv
verification/mcu_assertions.sv
verification/mcu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator and run; failure is found by searching the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module mcu_tb \
    -o mcu_sim > build.log 2>&1 \
    && ./obj_dir/mcu_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0
